// ==== project.f ====
logic/bubble_pkg.sv
logic/flash_read_if.sv
logic/spi_flash_reader.sv
logic/loop_map.sv
logic/position_page.sv
logic/bubble_loader.sv
logic/bubble_loader_top.sv
tests/clock_gen.sv
tests/flash_model.sv
tests/tb_bubble_loader.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f project.f \
    --top-module tb_bubble_loader -o sim_bubble_loader
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_bubble_loader)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "all tests passed"; then
    exit 0
fi
exit 1

// ==== tests/tb_bubble_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bubble_loader import bubble_pkg::*; ();

    localparam int NUM_RANDOM_PAGES = 4;
    localparam int NUM_PAGE_LOADS = NUM_RANDOM_PAGES + 2;
    localparam int PAGE_LOAD_BITS = (FILL_LOOPS + PAGE_LOOPS) * 16 / 15 + 16;  // one bad in 16
    localparam int WATCHDOG_CYCLES =
        12 * (BOOT_BITS + MAP_BITS + NUM_PAGE_LOADS * PAGE_LOAD_BITS) + 2000;

    logic        MCLK;
    logic        rst;
    img_t        img_num;
    logic [1:0]  acc_type;
    pos_t        abs_pos;
    logic        buf_wr;
    buf_addr_t   buf_addr;
    logic        buf_data;
    logic        busy;
    logic        spi_cs_n;
    logic        spi_clk;
    logic        spi_mosi;
    logic        spi_miso;
    flash_addr_t last_addr;
    int          cmd_count;
    int          bad_cmds;

    string       test_name = "reset";
    bit          expect_q [$];          // buffer bits still due in this load
    bit          map_shadow [0:4095];   // map bit m in flash order
    bit          seen_addr [int];
    buf_addr_t   load_base;
    int          writes;
    int          busy_falls;
    logic        busy_prev = 1'b0;
    int          mon_errors;
    int          main_errors;
    int          tests_run;
    int          tests_failed;
    bit          aborted;

    clock_gen u_clk (
        .MCLK (MCLK),
        .rst  (rst)
    );

    flash_model u_flash (
        .spi_cs_n  (spi_cs_n),
        .spi_clk   (spi_clk),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .last_addr (last_addr),
        .cmd_count (cmd_count),
        .bad_cmds  (bad_cmds)
    );

    bubble_loader_top uut (
        .MCLK     (MCLK),
        .rst      (rst),
        .img_num  (img_num),
        .acc_type (acc_type),
        .abs_pos  (abs_pos),
        .buf_wr   (buf_wr),
        .buf_addr (buf_addr),
        .buf_data (buf_data),
        .busy     (busy),
        .spi_cs_n (spi_cs_n),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    function automatic logic expected_flash_bit(img_t i, page_t p, int b);
        logic [31:0] h;
        if (p == BOOT_PAGE && b >= BOOT_BITS)
            return (b % 16) != 5;        // map is good except every 16th loop
        h = {5'b0, i, p, b[11:0]} * 32'h9E37_79B1;
        h = h ^ (h >> 16);
        return ^h;
    endfunction

    function automatic void show_value(string what, int exp, int act);
        $display("error %s: %s expected %0d actual %0d", test_name, what, exp, act);
    endfunction

    function automatic int total_errors();
        return main_errors + mon_errors + bad_cmds;
    endfunction

    task automatic check_int(string what, int exp, int act);
        assert (act == exp)
        else
        begin
            show_value(what, exp, act);
            main_errors++;
        end
    endtask

    task automatic queue_boot(img_t img);
        for (int b = 0; b < BOOT_BITS + MAP_BITS; b++)
            expect_q.push_back(expected_flash_bit(img, BOOT_PAGE, b));
        for (int m = 0; m < MAP_BITS; m++)
            map_shadow[m] = expected_flash_bit(img, BOOT_PAGE, BOOT_BITS + m);
    endtask

    task automatic queue_page(img_t img, page_t pg);
        int          good;
        int          data;
        logic [11:0] r;
        map_addr_t   m;
        good = 0;
        data = 0;
        r    = '0;
        while (data < PAGE_LOOPS)
        begin
            m = {r[11:4], ~r[3:0]};              // loop r holds map bit m
            if (!map_shadow[m])
                expect_q.push_back(1'b0);
            else if (good < FILL_LOOPS)
            begin
                expect_q.push_back(1'b1);
                good++;
            end
            else
            begin
                expect_q.push_back(expected_flash_bit(img, pg, data));
                data++;
            end
            r = r + 12'd1;
        end
    endtask

    task automatic finish_test(int base);
        tests_run++;
        if (total_errors() != base)
            tests_failed++;
        $display("test %s: %s", test_name, (total_errors() == base) ? "ok" : "failed");
    endtask

    task automatic check_reset();
        int base;
        base = total_errors();
        test_name = "reset";
        @(negedge MCLK);
        while (rst)
            @(negedge MCLK);
        check_int("spi_cs_n after reset", 1, int'(spi_cs_n));
        check_int("spi_clk after reset", 1, int'(spi_clk));
        check_int("buf_wr after reset", 0, int'(buf_wr));
        check_int("busy after reset", 0, int'(busy));
        repeat (20)
        begin
            @(negedge MCLK);
            check_int("busy with held request", 0, int'(busy));
            check_int("spi_cs_n with held request", 1, int'(spi_cs_n));
        end
        acc_type = 2'b00;
        repeat (2) @(negedge MCLK);
        finish_test(base);
    endtask

    task automatic run_load(string name, bit page_mode, img_t img, pos_t pos);
        int          base;
        int          limit;
        int          cycles;
        int          exp_len;
        int          falls_before;
        int          cmds_before;
        int          p;
        page_t       exp_page;
        flash_addr_t exp_addr;
        base = total_errors();
        test_name = name;
        expect_q.delete();
        if (page_mode)
        begin
            p = (int'(pos) + 1) % 4096;          // emulator runs one position ahead
            exp_page = page_t'((p + PAGE_SHIFT) % PAGE_COUNT);
            queue_page(img, exp_page);
            load_base = PAGE_BUF_BASE;
        end
        else
        begin
            exp_page = BOOT_PAGE;
            queue_boot(img);
            load_base = BOOT_BUF_BASE;
        end
        exp_addr     = {2'b00, img, exp_page, 7'b0};
        exp_len      = expect_q.size();
        limit        = 12 * exp_len + 200;
        falls_before = busy_falls;
        cmds_before  = cmd_count;
        @(negedge MCLK);
        img_num  = img;
        abs_pos  = pos;
        acc_type = {1'b1, page_mode};
        cycles   = 0;
        while (!busy && cycles < 4)
        begin
            @(negedge MCLK);
            cycles++;
        end
        if (!busy)
        begin
            $display("%s: load request was not accepted", name);
            main_errors++;
            aborted = 1'b1;
        end
        else
        begin
            cycles = 0;
            while (busy && cycles < limit)
            begin
                @(negedge MCLK);
                cycles++;
            end
            if (busy)
            begin
                $display("%s: busy did not fall within %0d cycles", name, limit);
                main_errors++;
                aborted = 1'b1;
            end
        end
        acc_type = 2'b00;
        repeat (3) @(negedge MCLK);
        check_int("buffer writes", exp_len, writes);
        check_int("busy falls", falls_before + 1, busy_falls);
        check_int("flash commands", cmds_before + 1, cmd_count);
        check_int("flash address", int'(exp_addr), int'(last_addr));
        finish_test(base);
    endtask

    // buffer shadow sampled mid-cycle
    always @(negedge MCLK)
    begin
        logic      exp_bit;
        buf_addr_t exp_addr;
        if (!rst)
        begin
            if (busy && !busy_prev)
            begin
                writes = 0;
                seen_addr.delete();
            end
            if (!busy && busy_prev)
                busy_falls++;
            busy_prev = busy;
            if (buf_wr)
            begin
                assert (busy)
                else
                begin
                    $display("%s: buffer write while busy was low", test_name);
                    mon_errors++;
                end
                assert (!seen_addr.exists(int'(buf_addr)))
                else
                begin
                    $display("%s: buffer address %0d written twice", test_name, buf_addr);
                    mon_errors++;
                end
                seen_addr[int'(buf_addr)] = 1'b1;
                exp_addr = load_base + buf_addr_t'(writes);
                assert (buf_addr == exp_addr)
                else
                begin
                    show_value("buffer address", int'(exp_addr), int'(buf_addr));
                    mon_errors++;
                end
                if (expect_q.size() == 0)
                begin
                    $display("%s: more buffer writes than expected", test_name);
                    mon_errors++;
                end
                else
                begin
                    exp_bit = expect_q.pop_front();
                    assert (buf_data == exp_bit)
                    else
                    begin
                        show_value("buffer data", int'(exp_bit), int'(buf_data));
                        mon_errors++;
                    end
                end
                writes++;
            end
        end
    end

    initial
    begin
        void'($urandom(66101));
        img_num  = '0;
        abs_pos  = '0;
        acc_type = 2'b10;                        // request already up as reset ends
        check_reset();
        if (!aborted)
            run_load("boot_map", 1'b0, img_t'($urandom), '0);
        if (!aborted)
            run_load("page_wrap", 1'b1, img_t'($urandom), 12'hFFF);
        if (!aborted)
            run_load("page_top", 1'b1, img_t'($urandom), 12'hFF0);  // rotation passes 2 x 2053
        for (int n = 1; n <= NUM_RANDOM_PAGES; n++)
            if (!aborted)
                run_load($sformatf("page_%0d", n), 1'b1, img_t'($urandom), pos_t'($urandom));
        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0 && !aborted)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge MCLK);
        $display("watchdog expired before the last load finished");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_model import bubble_pkg::*; (
    input  wire logic  spi_cs_n,
    input  wire logic  spi_clk,
    input  wire logic  spi_mosi,
    output logic       spi_miso,
    output flash_addr_t last_addr,
    output int         cmd_count,
    output int         bad_cmds
);

    logic [31:0] cmd_in = '0;    // command byte and address as received
    int          n_in = 0;       // command bits received
    int          k = 0;          // next data bit of the transaction

    // hashed parity of image, page and bit index
    // the bad-loop map sits after the boot bits of the boot page
    function automatic logic flash_bit(img_t i, page_t p, int b);
        logic [31:0] h;
        if (p == BOOT_PAGE && b >= BOOT_BITS)
            return (b % 16) != 5;
        h = {5'b0, i, p, b[11:0]} * 32'h9E37_79B1;
        h = h ^ (h >> 16);
        return ^h;
    endfunction

    initial
    begin
        spi_miso  = 1'b0;
        last_addr = '0;
        cmd_count = 0;
        bad_cmds  = 0;
    end

    always @(posedge spi_clk, negedge spi_clk, posedge spi_cs_n)
    begin
        if (spi_cs_n)
        begin
            n_in = 0;            // deselected until the next command
            k    = 0;
        end
        else if (spi_clk)
        begin
            if (n_in < 32)
            begin
                cmd_in = {cmd_in[30:0], spi_mosi};    // mosi sampled on rising clock
                n_in   = n_in + 1;
                if (n_in == 32)
                begin
                    last_addr = cmd_in[23:0];
                    cmd_count = cmd_count + 1;
                    assert (cmd_in[31:24] == READ_CMD && cmd_in[23:22] == 2'b00
                            && cmd_in[6:0] == 7'b0)
                    else
                    begin
                        $display("flash received a bad read command %h", cmd_in);
                        bad_cmds = bad_cmds + 1;
                    end
                end
            end
        end
        else if (n_in == 32)
        begin
            // next data bit goes out on the falling clock
            spi_miso = flash_bit(last_addr[21:19], last_addr[18:7], k);
            k        = k + 1;
        end
    end

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic MCLK,
    output logic rst
);

    localparam int RESET_CYCLES = 5;

    initial
    begin
        MCLK = 1'b0;
        forever #10 MCLK = ~MCLK;    // 20 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge MCLK);
        @(negedge MCLK);
        rst = 1'b0;                  // released on a falling edge
    end

endmodule

`default_nettype wire

// ==== logic/bubble_loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bubble_loader_top import bubble_pkg::*; (
    input  wire logic       MCLK,
    input  wire logic       rst,
    input  wire img_t       img_num,
    input  wire logic [1:0] acc_type,
    input  wire pos_t       abs_pos,
    output wire logic       buf_wr,
    output wire buf_addr_t  buf_addr,
    output wire logic       buf_data,
    output wire logic       busy,
    output wire logic       spi_cs_n,
    output wire logic       spi_clk,
    output wire logic       spi_mosi,
    input  wire logic       spi_miso
);

    logic  map_clear;
    logic  map_wr;
    logic  map_wr_data;
    logic  map_rd;
    logic  map_rd_data;
    logic  conv;
    pos_t  conv_pos;
    page_t page;

    flash_read_if fr ();

    spi_flash_reader u_reader (
        .MCLK     (MCLK),
        .rst      (rst),
        .bus      (fr.reader),
        .spi_cs_n (spi_cs_n),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    loop_map u_map (
        .MCLK    (MCLK),
        .rst     (rst),
        .clear   (map_clear),
        .wr      (map_wr),
        .wr_data (map_wr_data),
        .rd      (map_rd),
        .rd_data (map_rd_data)
    );

    position_page u_conv (
        .MCLK (MCLK),
        .rst  (rst),
        .conv (conv),
        .pos  (conv_pos),
        .page (page)
    );

    bubble_loader u_loader (
        .MCLK        (MCLK),
        .rst         (rst),
        .img_num     (img_num),
        .acc_type    (acc_type),
        .abs_pos     (abs_pos),
        .flash       (fr.loader),
        .map_clear   (map_clear),
        .map_wr      (map_wr),
        .map_wr_data (map_wr_data),
        .map_rd      (map_rd),
        .map_rd_data (map_rd_data),
        .conv        (conv),
        .conv_pos    (conv_pos),
        .page        (page),
        .buf_wr      (buf_wr),
        .buf_addr    (buf_addr),
        .buf_data    (buf_data),
        .busy        (busy)
    );

endmodule

`default_nettype wire

// ==== logic/bubble_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module bubble_loader import bubble_pkg::*; (
    input  wire logic       MCLK,
    input  wire logic       rst,
    input  wire img_t       img_num,
    input  wire logic [1:0] acc_type,
    input  wire pos_t       abs_pos,
    flash_read_if.loader    flash,
    output logic            map_clear,
    output logic            map_wr,
    output logic            map_wr_data,
    output logic            map_rd,
    input  wire logic       map_rd_data,
    output logic            conv,
    output pos_t            conv_pos,
    input  wire page_t      page,
    output logic            buf_wr,
    output buf_addr_t       buf_addr,
    output logic            buf_data,
    output logic            busy
);

    load_phase_t phase;
    logic [1:0]  step;        // sub-step inside a phase
    bit_cnt_t    cnt;         // bits or good loops done in this phase
    logic        req_d;       // acc_type[1] last cycle
    logic        page_mode;   // 1 = page load, 0 = boot load
    page_t       fetch_page;

    assign fetch_page = page_mode ? page : BOOT_PAGE;

    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            phase       <= ph_idle;
            step        <= '0;
            cnt         <= '0;
            req_d       <= 1'b1;   // a request held from reset is not an edge
            busy        <= 1'b0;
            buf_wr      <= 1'b0;
            map_wr      <= 1'b0;
            map_rd      <= 1'b0;
            map_clear   <= 1'b0;
            conv        <= 1'b0;
            flash.start <= 1'b0;
            flash.next  <= 1'b0;
            flash.stop  <= 1'b0;
        end
        else
        begin
            req_d       <= acc_type[1];
            buf_wr      <= 1'b0;
            map_wr      <= 1'b0;
            map_rd      <= 1'b0;
            map_clear   <= 1'b0;
            conv        <= 1'b0;
            flash.start <= 1'b0;
            flash.next  <= 1'b0;
            flash.stop  <= 1'b0;
            if (buf_wr)
                buf_addr <= buf_addr + buf_addr_t'(1);

            case (phase)
                ph_idle:
                begin
                    if (acc_type[1] && !req_d)
                    begin
                        page_mode <= acc_type[0];
                        conv_pos  <= abs_pos + pos_t'(1);  // emulator is one position ahead
                        conv      <= acc_type[0];
                        map_clear <= 1'b1;                 // rewind both map counters
                        busy      <= 1'b1;
                        step      <= '0;
                        phase     <= ph_cmd;
                    end
                end
                ph_wait_release:
                begin
                    busy <= 1'b0;
                    if (!acc_type[1])
                        phase <= ph_idle;
                end
                ph_cmd:
                begin
                    if (step != 2'd3)
                        step <= step + 2'd1;
                    if (step == 2'd1)
                    begin
                        flash.start <= 1'b1;               // page is valid by now
                        flash.addr  <= {2'b00, img_num, fetch_page, 7'b0};
                    end
                    if (step == 2'd3 && flash.ready)
                    begin
                        step     <= '0;
                        cnt      <= '0;
                        buf_addr <= page_mode ? PAGE_BUF_BASE : BOOT_BUF_BASE;
                        phase    <= page_mode ? ph_fill : ph_boot;
                    end
                end
                ph_boot, ph_map:
                begin
                    if (step == 2'd0)
                    begin
                        if (flash.ready)
                        begin
                            flash.next <= 1'b1;
                            step       <= 2'd1;
                        end
                    end
                    else if (flash.bit_valid)
                    begin
                        buf_wr   <= 1'b1;
                        buf_data <= flash.bit_data;
                        step     <= '0;
                        cnt      <= cnt + bit_cnt_t'(1);
                        if (phase == ph_map)
                        begin
                            map_wr      <= 1'b1;           // map goes to buffer and table
                            map_wr_data <= flash.bit_data;
                            if (cnt == bit_cnt_t'(MAP_BITS - 1))
                            begin
                                flash.stop <= 1'b1;
                                phase      <= ph_wait_release;
                            end
                        end
                        else if (cnt == bit_cnt_t'(BOOT_BITS - 1))
                        begin
                            cnt   <= '0;
                            phase <= ph_map;
                        end
                    end
                end
                default:
                begin
                    case (step)
                        2'd0:
                        begin
                            map_rd <= 1'b1;
                            step   <= 2'd1;
                        end
                        2'd1:
                            step <= 2'd2;                  // map data due next cycle
                        2'd2:
                        begin
                            if (!map_rd_data)
                            begin
                                buf_wr   <= 1'b1;          // bad loop takes no flash bit
                                buf_data <= 1'b0;
                                step     <= '0;
                            end
                            else if (phase == ph_fill)
                            begin
                                buf_wr   <= 1'b1;
                                buf_data <= 1'b1;
                                step     <= '0;
                                cnt      <= cnt + bit_cnt_t'(1);
                                if (cnt == bit_cnt_t'(FILL_LOOPS - 1))
                                begin
                                    cnt   <= '0;
                                    phase <= ph_page;
                                end
                            end
                            else
                            begin
                                flash.next <= 1'b1;
                                step       <= 2'd3;
                            end
                        end
                        default:
                        begin
                            if (flash.bit_valid)
                            begin
                                buf_wr   <= 1'b1;
                                buf_data <= flash.bit_data;
                                step     <= '0;
                                cnt      <= cnt + bit_cnt_t'(1);
                                if (cnt == bit_cnt_t'(PAGE_LOOPS - 1))
                                begin
                                    flash.stop <= 1'b1;
                                    phase      <= ph_wait_release;
                                end
                            end
                        end
                    endcase
                end
            endcase
        end
    end

    a_wr_in_load: assert property (@(posedge MCLK) disable iff (rst)
        buf_wr |-> busy)
        else $error("buffer write outside a load");

endmodule

`default_nettype wire

// ==== logic/position_page.sv ====
`timescale 1ns/1ps
`default_nettype none

module position_page import bubble_pkg::*; (
    input  wire logic  MCLK,
    input  wire logic  rst,
    input  wire logic  conv,
    input  wire pos_t  pos,
    output page_t      page
);

    logic [12:0] sum;    // rotated position before reduction

    assign sum = {1'b0, pos} + 13'(PAGE_SHIFT);

    always_ff @(posedge MCLK)
    begin
        if (rst)
            page <= '0;
        else if (conv)
        begin
            // positions near the top of the 12-bit range wrap twice
            if (sum >= 13'(2 * PAGE_COUNT))
                page <= page_t'(sum - 13'(2 * PAGE_COUNT));
            else if (sum >= 13'(PAGE_COUNT))
                page <= page_t'(sum - 13'(PAGE_COUNT));
            else
                page <= page_t'(sum);
        end
    end

    a_page_range: assert property (@(posedge MCLK) disable iff (rst)
        conv |=> page < page_t'(PAGE_COUNT))
        else $error("converted page out of range");

endmodule

`default_nettype wire

// ==== logic/loop_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module loop_map import bubble_pkg::*; (
    input  wire logic MCLK,
    input  wire logic rst,
    input  wire logic clear,
    input  wire logic wr,
    input  wire logic wr_data,
    input  wire logic rd,
    output logic      rd_data
);

    logic      loop_ok [2**$bits(map_addr_t)];   // 1 = good loop
    map_addr_t wr_idx;
    map_addr_t rd_idx;

    // the map is stored with each nibble of loops reversed,
    // so a plain read walks the loops in bubble order
    always_ff @(posedge MCLK)
    begin
        if (wr)
            loop_ok[{wr_idx[11:4], ~wr_idx[3:0]}] <= wr_data;
        if (rd)
            rd_data <= loop_ok[rd_idx];
    end

    always_ff @(posedge MCLK)
    begin
        if (rst || clear)
        begin
            wr_idx <= '0;
            rd_idx <= '0;
        end
        else
        begin
            if (wr)
                wr_idx <= wr_idx + map_addr_t'(1);
            if (rd)
                rd_idx <= rd_idx + map_addr_t'(1);
        end
    end

    // loader never fills and walks the map at once
    a_no_rd_wr: assert property (@(posedge MCLK) disable iff (rst)
        !(wr && rd))
        else $error("loop map read and write in the same cycle");

endmodule

`default_nettype wire

// ==== logic/spi_flash_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader import bubble_pkg::*; (
    input  wire logic    MCLK,
    input  wire logic    rst,
    flash_read_if.reader bus,
    output logic         spi_cs_n,
    output logic         spi_clk,
    output logic         spi_mosi,
    input  wire logic    spi_miso
);

    typedef enum logic [1:0] {
        s_idle,
        s_cmd,
        s_ready,
        s_clk_low
    } rd_state_t;

    rd_state_t   state;
    logic [31:0] shift;      // command byte then address
    logic [4:0]  bit_cnt;
    logic        half;       // second half of a command bit

    assign bus.ready = (state == s_idle) || (state == s_ready);

    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            state         <= s_idle;
            spi_cs_n      <= 1'b1;
            spi_clk       <= 1'b1;
            spi_mosi      <= 1'b0;
            half          <= 1'b0;
            bit_cnt       <= '0;
            bus.bit_valid <= 1'b0;
        end
        else
        begin
            bus.bit_valid <= 1'b0;
            if (bus.stop)
            begin
                state    <= s_idle;
                spi_cs_n <= 1'b1;
                spi_clk  <= 1'b1;    // park clock high
            end
            else
            begin
                case (state)
                    s_idle:
                    begin
                        if (bus.start)
                        begin
                            shift    <= {READ_CMD, bus.addr};
                            bit_cnt  <= '0;
                            half     <= 1'b0;
                            spi_cs_n <= 1'b0;
                            state    <= s_cmd;
                        end
                    end
                    s_cmd:
                    begin
                        if (!half)
                        begin
                            spi_clk  <= 1'b0;               // mosi changes with clock low
                            spi_mosi <= shift[31];
                            shift    <= {shift[30:0], 1'b0};
                            half     <= 1'b1;
                        end
                        else
                        begin
                            spi_clk <= 1'b1;                // flash samples here
                            half    <= 1'b0;
                            bit_cnt <= bit_cnt + 5'd1;
                            if (bit_cnt == 5'd31)
                                state <= s_ready;           // cs stays low
                        end
                    end
                    s_ready:
                    begin
                        if (bus.next)
                        begin
                            spi_clk <= 1'b0;                // flash drives next bit
                            state   <= s_clk_low;
                        end
                    end
                    default:
                    begin
                        spi_clk       <= 1'b1;
                        bus.bit_data  <= spi_miso;          // sampled on rising clock
                        bus.bit_valid <= 1'b1;
                        state         <= s_ready;
                    end
                endcase
            end
        end
    end

    // loader must wait for ready before asking for a bit
    a_next_when_ready: assert property (@(posedge MCLK) disable iff (rst)
        bus.next |-> bus.ready)
        else $error("next requested while the reader was busy");

endmodule

`default_nettype wire

// ==== logic/flash_read_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface flash_read_if import bubble_pkg::*; ();

    logic        start;      // open a read at addr
    flash_addr_t addr;
    logic        next;       // one more bit please
    logic        stop;       // release chip select
    logic        bit_valid;
    logic        bit_data;
    logic        ready;      // reader can take start or next

    modport loader (
        output start, addr, next, stop,
        input  bit_valid, bit_data, ready
    );

    modport reader (
        input  start, addr, next, stop,
        output bit_valid, bit_data, ready
    );

endinterface

`default_nettype wire

// ==== logic/bubble_pkg.sv ====
`default_nettype none

package bubble_pkg;

    typedef logic [2:0]  img_t;         // flash image select
    typedef logic [11:0] pos_t;         // absolute bubble position
    typedef logic [11:0] page_t;        // bubble page number
    typedef logic [14:0] buf_addr_t;    // bubble output buffer address
    typedef logic [23:0] flash_addr_t;  // 00 iii pppppppppppp 0000000
    typedef logic [11:0] map_addr_t;    // bad-loop map index
    typedef logic [11:0] bit_cnt_t;     // bits moved within one phase

    typedef enum logic [2:0] {
        ph_idle,
        ph_wait_release,
        ph_cmd,
        ph_boot,
        ph_map,
        ph_fill,
        ph_page
    } load_phase_t;

    localparam int PAGE_COUNT = 2053;                // data pages per image
    localparam int PAGE_SHIFT = 45;                  // position to page rotation
    localparam page_t BOOT_PAGE = 12'h805;           // bootloader and map live here
    localparam int BOOT_BITS = 2656;
    localparam int MAP_BITS = 1168;
    localparam int FILL_LOOPS = 6;                   // leading filler loops in a page
    localparam int PAGE_LOOPS = 1030;                // good loops carrying data
    localparam buf_addr_t BOOT_BUF_BASE = 15'd4106;
    localparam buf_addr_t PAGE_BUF_BASE = 15'd14336;
    localparam logic [7:0] READ_CMD = 8'h03;         // plain read with 24-bit address

endpackage

`default_nettype wire
